// ==== logic/command_output.sv ====
`timescale 1ns/1ns

module command_output
  import sdram_cmd_pkg::*;
(
  input  logic                 INPUT_CLK,
  input  logic                 RST,
  input  logic                 issue,
  input  sd_cmd_e              issue_cmd,
  input  logic [ROW_W-1:0]     row_q,
  input  logic [BANK_W-1:0]    bank_q,
  input  logic [COL_W-1:0]     col_q,
  input  logic [MASK_W-1:0]    mask_q,
  output sd_cmd_e              sd_command,
  output logic [SD_ADDR_W-1:0] sd_address,
  output logic [BANK_W-1:0]    sd_bank,
  output logic                 grant,
  output logic [MASK_W-1:0]    write_mask
);

  logic [SD_ADDR_W-1:0] fmt_addr;
  logic                 is_access;

  // ------------------------------
  // Address format per command
  // ------------------------------
  always_comb
  begin
    case (issue_cmd)
      ACTV:       fmt_addr = row_q;
      READ, WRTE: fmt_addr = {{(SD_ADDR_W-COL_W-1){1'b0}}, col_q, 1'b0};
      PRCH:       fmt_addr = PRCH_ALL_ADDR;
      default:    fmt_addr = '0;    // ARSR
    endcase
  end

  assign is_access = issue && ((issue_cmd == READ) || (issue_cmd == WRTE));

  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      sd_command <= NOOP;
      grant      <= 1'b0;
    end
    else
    begin
      sd_command <= issue ? issue_cmd : NOOP;
      grant      <= is_access;              // Same cycle as READ/WRTE
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issue)
    begin
      sd_address <= fmt_addr;
      sd_bank    <= bank_q;
    end
    if (is_access)
      write_mask <= mask_q;
  end

endmodule

// ==== logic/command_sequencer.sv ====
`timescale 1ns/1ns

module command_sequencer
  import sdram_cmd_pkg::*;
(
  input  logic              INPUT_CLK,
  input  logic              RST,
  input  logic              req_q,
  input  logic              we_q,
  input  logic [ROW_W-1:0]  row_q,
  input  logic [BANK_W-1:0] bank_q,
  input  logic              refresh_pending,
  output logic              issue,
  output sd_cmd_e           issue_cmd,
  output logic              refresh_done
);

  seq_state_e        state;
  logic [GAP_W-1:0]  gap_cnt;

  logic              page_open;
  logic [ROW_W-1:0]  open_row;
  logic [BANK_W-1:0] open_bank;

  logic              page_hit;
  sd_cmd_e           next_cmd;
  logic [GAP_W-1:0]  next_gap;

  assign page_hit = page_open && (open_row == row_q) && (open_bank == bank_q);

  // ------------------------------
  // Command choice
  // ------------------------------
  always_comb
  begin
    next_cmd = NOOP;
    if (refresh_pending)
      next_cmd = page_open ? PRCH : ARSR;     // Refresh first
    else if (req_q)
    begin
      if (page_hit)
        next_cmd = we_q ? WRTE : READ;
      else if (page_open)
        next_cmd = PRCH;                      // Wrong page closes all banks
      else
        next_cmd = ACTV;
    end
  end

  always_comb
  begin
    case (next_cmd)
      ACTV:    next_gap = GAP_ACTV;
      PRCH:    next_gap = GAP_PRCH;
      ARSR:    next_gap = GAP_ARSR;
      default: next_gap = GAP_ACCESS;
    endcase
  end

  assign issue        = (state == IDLE) && (next_cmd != NOOP);
  assign issue_cmd    = next_cmd;
  assign refresh_done = issue && (next_cmd == ARSR);

  // ------------------------------
  // State and gap counter
  // ------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
    begin
      state   <= IDLE;
      gap_cnt <= '0;
    end
    else
    begin
      case (state)
        IDLE:
          if (issue)
          begin
            gap_cnt <= next_gap - 1'b1;   // Counts down to zero
            state   <= GAP;
          end
        GAP:
          if (gap_cnt == '0)
            state <= IDLE;
          else
            gap_cnt <= gap_cnt - 1'b1;
        default:
          state <= IDLE;
      endcase
    end
  end

  // ------------------------------
  // Open page tracking
  // ------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      page_open <= 1'b0;
    else if (issue)
    begin
      if (next_cmd == ACTV)
        page_open <= 1'b1;
      else if ((next_cmd == PRCH) || (next_cmd == ARSR))
        page_open <= 1'b0;
    end
  end

  always_ff @(posedge INPUT_CLK)
  begin
    if (issue && (next_cmd == ACTV))
    begin
      open_row  <= row_q;
      open_bank <= bank_q;
    end
  end

endmodule

// ==== logic/request_capture.sv ====
`timescale 1ns/1ns

module request_capture
  import sdram_cmd_pkg::*;
(
  input  logic              INPUT_CLK,
  input  logic              RST,
  input  logic              req,
  input  logic              we,
  input  logic [ADDR_W-1:0] address,
  input  logic [MASK_W-1:0] write_mask_in,
  input  logic              refresh_strobe,
  input  logic              refresh_done,
  output logic              req_q,
  output logic              we_q,
  output logic [ROW_W-1:0]  row_q,
  output logic [BANK_W-1:0] bank_q,
  output logic [COL_W-1:0]  col_q,
  output logic [MASK_W-1:0] mask_q,
  output logic              refresh_pending
);

  // ------------------------------
  // Request level
  // ------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      req_q <= 1'b0;
    else
      req_q <= req;
  end

  // Operands held stable by the requester until grant
  always_ff @(posedge INPUT_CLK)
  begin
    we_q   <= we;
    row_q  <= address[ADDR_W-1 -: ROW_W];
    bank_q <= address[COL_W +: BANK_W];
    col_q  <= address[COL_W-1:0];
    mask_q <= write_mask_in;
  end

  // ------------------------------
  // Pending refresh
  // ------------------------------
  always_ff @(posedge INPUT_CLK)
  begin
    if (RST)
      refresh_pending <= 1'b0;
    else if (refresh_strobe)
      refresh_pending <= 1'b1;    // New strobe beats the clear
    else if (refresh_done)
      refresh_pending <= 1'b0;
  end

endmodule

// ==== logic/sdram_cmd_pkg.sv ====
package sdram_cmd_pkg;

  // ------------------------------
  // Request address layout
  // ------------------------------
  localparam int ADDR_W = 26;
  localparam int ROW_W  = 14;       // Bits 25..12
  localparam int BANK_W = 3;        // Bits 11..9
  localparam int COL_W  = 9;        // Bits 8..0

  localparam int SD_ADDR_W = 14;
  localparam int MASK_W    = 4;

  // A10 high selects all banks on precharge
  localparam logic [SD_ADDR_W-1:0] PRCH_ALL_ADDR = 14'h0400;

  // ------------------------------
  // NOOP gap after each command
  // ------------------------------
  localparam int GAP_W = 4;

  localparam logic [GAP_W-1:0] GAP_ACTV   = 4'd3;
  localparam logic [GAP_W-1:0] GAP_PRCH   = 4'd3;
  localparam logic [GAP_W-1:0] GAP_ARSR   = 4'd10;
  localparam logic [GAP_W-1:0] GAP_ACCESS = 4'd4;   // READ and WRTE

  // SDRAM command pins {RAS#, CAS#, WE#}
  typedef enum logic [2:0] {
    NOOP = 3'b111,
    ACTV = 3'b011,    // Row open
    READ = 3'b101,
    WRTE = 3'b100,
    PRCH = 3'b010,    // Row close
    ARSR = 3'b001     // Auto refresh
  } sd_cmd_e;

  typedef enum logic {
    IDLE,
    GAP
  } seq_state_e;

endpackage

// ==== logic/sdram_cmd_top.sv ====
`timescale 1ns/1ns

module sdram_cmd_top
  import sdram_cmd_pkg::*;
(
  input  logic                 INPUT_CLK,
  input  logic                 RST,
  input  logic                 req,
  input  logic                 we,
  input  logic [ADDR_W-1:0]    address,
  input  logic [MASK_W-1:0]    write_mask_in,
  input  logic                 refresh_strobe,
  output sd_cmd_e              sd_command,
  output logic [SD_ADDR_W-1:0] sd_address,
  output logic [BANK_W-1:0]    sd_bank,
  output logic                 grant,
  output logic [MASK_W-1:0]    write_mask
);

  logic              req_q;
  logic              we_q;
  logic [ROW_W-1:0]  row_q;
  logic [BANK_W-1:0] bank_q;
  logic [COL_W-1:0]  col_q;
  logic [MASK_W-1:0] mask_q;
  logic              refresh_pending;
  logic              refresh_done;
  logic              issue;
  sd_cmd_e           issue_cmd;

  request_capture i_request_capture (
    .INPUT_CLK       (INPUT_CLK),
    .RST             (RST),
    .req             (req),
    .we              (we),
    .address         (address),
    .write_mask_in   (write_mask_in),
    .refresh_strobe  (refresh_strobe),
    .refresh_done    (refresh_done),
    .req_q           (req_q),
    .we_q            (we_q),
    .row_q           (row_q),
    .bank_q          (bank_q),
    .col_q           (col_q),
    .mask_q          (mask_q),
    .refresh_pending (refresh_pending)
  );

  command_sequencer i_command_sequencer (
    .INPUT_CLK       (INPUT_CLK),
    .RST             (RST),
    .req_q           (req_q),
    .we_q            (we_q),
    .row_q           (row_q),
    .bank_q          (bank_q),
    .refresh_pending (refresh_pending),
    .issue           (issue),
    .issue_cmd       (issue_cmd),
    .refresh_done    (refresh_done)
  );

  command_output i_command_output (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .issue      (issue),
    .issue_cmd  (issue_cmd),
    .row_q      (row_q),
    .bank_q     (bank_q),
    .col_q      (col_q),
    .mask_q     (mask_q),
    .sd_command (sd_command),
    .sd_address (sd_address),
    .sd_bank    (sd_bank),
    .grant      (grant),
    .write_mask (write_mask)
  );

endmodule

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the scheduler testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --top-module sdram_cmd_tb -f sdram_cmd_top.f \
  -o sdram_cmd_sim \
  && ./obj_dir/sdram_cmd_sim | tee /dev/stderr | grep -x "PASS: all tests" > /dev/null \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

// ==== sdram_cmd_top.f ====
logic/sdram_cmd_pkg.sv
logic/request_capture.sv
logic/command_sequencer.sv
logic/command_output.sv
logic/sdram_cmd_top.sv
verification/sdram_cmd_chk.sv
verification/sdram_cmd_tb.sv

// ==== verification/sdram_cmd_chk.sv ====
`timescale 1ns/1ns

module sdram_cmd_chk
  import sdram_cmd_pkg::*;
(
  input logic    INPUT_CLK,
  input logic    RST,
  input sd_cmd_e sd_command,
  input logic    grant
);

  grant_with_access: assert property (
    @(posedge INPUT_CLK) disable iff (RST)
    grant |-> ((sd_command == READ) || (sd_command == WRTE))
  ) else $error("grant high without READ or WRTE on sd_command");

  // At least one NOOP after every command
  noop_after_cmd: assert property (
    @(posedge INPUT_CLK) disable iff (RST)
    (sd_command != NOOP) |=> (sd_command == NOOP)
  ) else $error("command not followed by a NOOP cycle");

  noop_in_reset: assert property (
    @(posedge INPUT_CLK)
    RST |=> (sd_command == NOOP)
  ) else $error("sd_command not NOOP during reset");

endmodule

// ==== verification/sdram_cmd_tb.sv ====
`timescale 1ns/1ns

module sdram_cmd_tb
  import sdram_cmd_pkg::*;
();

  localparam int N_ENTRIES      = 6;
  localparam int TIMEOUT_CYCLES = 100;

  logic                 INPUT_CLK = 1'b0;
  logic                 RST;
  logic                 req;
  logic                 we;
  logic [ADDR_W-1:0]    address;
  logic [MASK_W-1:0]    write_mask_in;
  logic                 refresh_strobe;
  sd_cmd_e              sd_command;
  logic [SD_ADDR_W-1:0] sd_address;
  logic [BANK_W-1:0]    sd_bank;
  logic                 grant;
  logic [MASK_W-1:0]    write_mask;

  // ------------------------------
  // Stimulus table
  // ------------------------------
  logic                 t_refresh [N_ENTRIES];
  logic [ADDR_W-1:0]    t_addr    [N_ENTRIES];
  logic [COL_W-1:0]     t_col     [N_ENTRIES];
  logic [BANK_W-1:0]    t_bank    [N_ENTRIES];
  logic                 t_we      [N_ENTRIES];
  logic [MASK_W-1:0]    t_mask    [N_ENTRIES];
  int                   t_count   [N_ENTRIES];
  sd_cmd_e              t_cmd     [N_ENTRIES][3];
  logic [SD_ADDR_W-1:0] t_sdaddr  [N_ENTRIES][3];

  // Commands seen by the monitor for the current entry
  int                   seen_n;
  sd_cmd_e              seen_cmd  [3];
  logic [SD_ADDR_W-1:0] seen_addr [3];
  logic [BANK_W-1:0]    seen_bank [3];
  logic                 seen_grant;
  logic [MASK_W-1:0]    seen_mask;
  logic                 done;
  logic                 timed_out;
  int                   wait_cycles;

  integer seed;
  int     error_count;
  int     passed;
  int     failed;

  sdram_cmd_top i_sdram_cmd_top (
    .INPUT_CLK      (INPUT_CLK),
    .RST            (RST),
    .req            (req),
    .we             (we),
    .address        (address),
    .write_mask_in  (write_mask_in),
    .refresh_strobe (refresh_strobe),
    .sd_command     (sd_command),
    .sd_address     (sd_address),
    .sd_bank        (sd_bank),
    .grant          (grant),
    .write_mask     (write_mask)
  );

  bind sdram_cmd_top sdram_cmd_chk i_sdram_cmd_chk (
    .INPUT_CLK  (INPUT_CLK),
    .RST        (RST),
    .sd_command (sd_command),
    .grant      (grant)
  );

  always #20 INPUT_CLK = ~INPUT_CLK;

  // Column goes out shifted left by one with upper bits zero
  function automatic logic [SD_ADDR_W-1:0] access_addr(input logic [COL_W-1:0] col);
    logic [SD_ADDR_W-1:0] a;
    a = '0;
    a[COL_W:1] = col;
    return a;
  endfunction

  task automatic set_request(input int idx, input logic [ROW_W-1:0] row,
                             input logic [BANK_W-1:0] bank, input logic wr,
                             input logic [MASK_W-1:0] mask);
    integer r;
    r = $random(seed);
    t_refresh[idx] = 1'b0;
    t_col[idx]     = r[COL_W-1:0];
    t_bank[idx]    = bank;
    t_addr[idx]    = {row, bank, r[COL_W-1:0]};
    t_we[idx]      = wr;
    t_mask[idx]    = mask;
    t_count[idx]   = 0;
  endtask

  task automatic set_refresh(input int idx);
    t_refresh[idx] = 1'b1;
    t_col[idx]     = '0;
    t_bank[idx]    = '0;
    t_addr[idx]    = '0;
    t_we[idx]      = 1'b0;
    t_mask[idx]    = '0;
    t_count[idx]   = 0;
  endtask

  task automatic set_expect(input int idx, input sd_cmd_e cmd, input logic [SD_ADDR_W-1:0] a);
    t_cmd[idx][t_count[idx]]    = cmd;
    t_sdaddr[idx][t_count[idx]] = a;
    t_count[idx]++;
  endtask

  // ------------------------------
  // Monitor and drivers
  // ------------------------------
  task automatic sample_cycle(input int idx);
    @(negedge INPUT_CLK);
    wait_cycles++;
    if (sd_command != NOOP)
    begin
      if (seen_n < 3)
      begin
        seen_cmd[seen_n]  = sd_command;
        seen_addr[seen_n] = sd_address;
        seen_bank[seen_n] = sd_bank;
      end
      seen_n++;
      if (t_refresh[idx] && (sd_command == ARSR))
        done = 1'b1;
    end
    if (grant)
    begin
      seen_grant = 1'b1;
      seen_mask  = write_mask;
      if (!t_refresh[idx])
        done = 1'b1;
    end
  endtask

  task automatic run_entry(input int idx);
    seen_n      = 0;
    seen_grant  = 1'b0;
    done        = 1'b0;
    timed_out   = 1'b0;
    wait_cycles = 0;
    @(posedge INPUT_CLK);
    #2;
    if (t_refresh[idx])
      refresh_strobe = 1'b1;    // One-cycle pulse
    else
    begin
      req           = 1'b1;
      we            = t_we[idx];
      address       = t_addr[idx];
      write_mask_in = t_mask[idx];
    end
    sample_cycle(idx);
    @(posedge INPUT_CLK);
    #2;
    refresh_strobe = 1'b0;
    while (!done && (wait_cycles < TIMEOUT_CYCLES))
      sample_cycle(idx);
    if (!done)
      timed_out = 1'b1;
    @(posedge INPUT_CLK);
    #2;
    req = 1'b0;                 // Requester lets go after grant
  endtask

  task automatic check_entry(input int idx);
    int errs;
    int k;
    errs = 0;
    if (timed_out)
    begin
      $display("entry %0d timed out: no %s within %0d cycles", idx,
               t_refresh[idx] ? "ARSR" : "grant", TIMEOUT_CYCLES);
      errs++;
    end
    else
    begin
      if (seen_n != t_count[idx])
      begin
        $display("CHECK FAILED at %0t ns: entry %0d gave %0d commands, expected %0d",
                 $time, idx, seen_n, t_count[idx]);
        errs++;
      end
      for (k = 0; k < 3; k++)
      begin
        if ((k < t_count[idx]) && (k < seen_n))
        begin
          if (seen_cmd[k] != t_cmd[idx][k])
          begin
            $display("CHECK FAILED at %0t ns: entry %0d command %0d is %s, expected %s",
                     $time, idx, k, seen_cmd[k].name(), t_cmd[idx][k].name());
            errs++;
          end
          if (seen_addr[k] != t_sdaddr[idx][k])
          begin
            $display("CHECK FAILED at %0t ns: entry %0d address %0d is %h, expected %h",
                     $time, idx, k, seen_addr[k], t_sdaddr[idx][k]);
            errs++;
          end
          if (!t_refresh[idx] && (seen_bank[k] != t_bank[idx]))
          begin
            $display("CHECK FAILED at %0t ns: entry %0d bank %0d is %0d, expected %0d",
                     $time, idx, k, seen_bank[k], t_bank[idx]);
            errs++;
          end
        end
      end
      if (t_refresh[idx] && seen_grant)
      begin
        $display("CHECK FAILED at %0t ns: entry %0d got grant on a refresh", $time, idx);
        errs++;
      end
      if (!t_refresh[idx] && t_we[idx] && (seen_mask != t_mask[idx]))
      begin
        $display("CHECK FAILED at %0t ns: entry %0d write_mask is %h, expected %h",
                 $time, idx, seen_mask, t_mask[idx]);
        errs++;
      end
    end
    error_count += errs;
    if (errs == 0)
      passed++;
    else
      failed++;
    $display("entry %0d (%s): %s", idx, t_refresh[idx] ? "refresh" : "request",
             (errs == 0) ? "ok" : "failed");
  endtask

  // Outputs stay quiet between reset and the first request
  task automatic check_idle();
    int errs;
    errs = 0;
    repeat (3)
    begin
      @(negedge INPUT_CLK);
      if ((sd_command !== NOOP) || (grant !== 1'b0))
      begin
        $display("CHECK FAILED at %0t ns: sd_command %s grant %b after reset",
                 $time, sd_command.name(), grant);
        errs++;
      end
    end
    error_count += errs;
    if (errs == 0)
      passed++;
    else
      failed++;
    $display("reset: %s", (errs == 0) ? "ok" : "failed");
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial
  begin
    RST            = 1'b1;
    req            = 1'b0;
    we             = 1'b0;
    address        = '0;
    write_mask_in  = '0;
    refresh_strobe = 1'b0;
    seed           = 63;
    error_count    = 0;
    passed         = 0;
    failed         = 0;

    set_request(0, 14'h0123, 3'd2, 1'b0, 4'h0);   // Closed bank read
    set_expect(0, ACTV, 14'h0123);
    set_expect(0, READ, access_addr(t_col[0]));
    set_request(1, 14'h0123, 3'd2, 1'b1, 4'hA);   // Page hit
    set_expect(1, WRTE, access_addr(t_col[1]));
    set_request(2, 14'h02AB, 3'd5, 1'b0, 4'h0);   // Page miss
    set_expect(2, PRCH, 14'h0400);
    set_expect(2, ACTV, 14'h02AB);
    set_expect(2, READ, access_addr(t_col[2]));
    set_refresh(3);
    set_expect(3, PRCH, 14'h0400);
    set_expect(3, ARSR, 14'h0000);
    set_request(4, 14'h02AB, 3'd5, 1'b1, 4'h5);   // Page closed by refresh
    set_expect(4, ACTV, 14'h02AB);
    set_expect(4, WRTE, access_addr(t_col[4]));
    set_request(5, 14'h02AB, 3'd1, 1'b1, 4'h3);   // Same row in another bank
    set_expect(5, PRCH, 14'h0400);
    set_expect(5, ACTV, 14'h02AB);
    set_expect(5, WRTE, access_addr(t_col[5]));

    repeat (5) @(posedge INPUT_CLK);
    #2;
    RST = 1'b0;
    check_idle();

    for (int i = 0; i < N_ENTRIES; i++)
    begin
      run_entry(i);
      check_entry(i);
    end

    $display("tests %0d, passed %0d, failed %0d, errors %0d",
             passed + failed, passed, failed, error_count);
    if (error_count == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule
